// ==== hw/divider_defines.svh ====
// divider sizing; DIV_DIGITS_PER_STEP must divide DIV_WIDTH and DIV_COUNT_BITS must hold DIV_STEPS
`ifndef DIVIDER_DEFINES_SVH
`define DIVIDER_DEFINES_SVH

// operand width for dividend, divisor, quotient and remainder
`define DIV_WIDTH 32

// quotient bits resolved per clock
// one controlled-subtract stage per bit
`define DIV_DIGITS_PER_STEP 4

// clocks of calculation per division
`define DIV_STEPS (`DIV_WIDTH / `DIV_DIGITS_PER_STEP)

// step counter width, must reach DIV_STEPS - 1
`define DIV_COUNT_BITS 4

`endif

// ==== hw/divider_pkg.sv ====
// types for the unsigned divider; widths come from the defines header on the include path
`default_nettype none

`include "divider_defines.svh"

package divider_pkg;

    // dividend, divisor, quotient or remainder
    typedef logic [`DIV_WIDTH-1:0] div_word_t;

    // quotient bits of one step, msb resolved first
    typedef logic [`DIV_DIGITS_PER_STEP-1:0] div_digits_t;

    // calculation step index
    typedef logic [`DIV_COUNT_BITS-1:0] div_count_t;

    // control states
    typedef enum logic [1:0] {
        div_idle = 2'd0,
        div_calc = 2'd1,
        div_done = 2'd2
    } div_state_e;

endpackage

`default_nettype wire

// ==== hw/div_control_fsm.sv ====
// divider control; start is only taken while ready is high, no abort once a division has begun
`timescale 1ns/10ps
`default_nettype none

`include "divider_defines.svh"

module div_control_fsm (
    input  wire  ctl_clk,
    input  wire  reset,
    input  wire  start,
    input  wire  last_step,
    output logic ready,
    output logic load,
    output logic calc_en,
    output logic finish
);
    import divider_pkg::*;

    div_state_e state;
    div_state_e next_state;

    // request taken only while idle or done
    assign load = start & ready;

    // datapath shifts in every calc cycle
    assign calc_en = (state == div_calc);

    // high for the cycle after calc is left
    // results are taken from the registers at its end
    assign finish = (state == div_done);

    // next state
    always_comb begin
        next_state = state;
        case (state)
            div_idle: begin
                if (load) begin
                    next_state = div_calc;
                end
            end
            div_calc: begin
                // last of the DIV_STEPS steps
                if (last_step) begin
                    next_state = div_done;
                end
            end
            div_done: begin
                // back-to-back request skips idle
                if (load) begin
                    next_state = div_calc;
                end else begin
                    next_state = div_idle;
                end
            end
            default: begin
                next_state = div_idle;
            end
        endcase
    end

    always_ff @(posedge ctl_clk) begin
        if (!reset) begin
            state <= div_idle;
        end else begin
            state <= next_state;
        end
    end

    // ready tracks the state it is registered with
    // low through calc and while in reset
    always_ff @(posedge ctl_clk) begin
        if (!reset) begin
            ready <= 1'b0;
        end else begin
            ready <= (next_state != div_calc);
        end
    end

endmodule

`default_nettype wire

// ==== hw/div_step_counter.sv ====
// step counter; holds at zero outside calculation, so calc_en must stay high for a whole division
`timescale 1ns/10ps
`default_nettype none

`include "divider_defines.svh"

module div_step_counter (
    input  wire  ctl_clk,
    input  wire  reset,
    input  wire  calc_en,
    output logic last_step
);
    import divider_pkg::*;

    div_count_t count;

    // zero on entry to calc
    // one increment per resolved step
    always_ff @(posedge ctl_clk) begin
        if (!reset) begin
            count <= '0;
        end else if (calc_en) begin
            count <= count + 1'b1;
        end else begin
            count <= '0;
        end
    end

    // final step in progress
    // fsm leaves calc on this edge
    assign last_step = (count == div_count_t'(`DIV_STEPS - 1));

endmodule

`default_nettype wire

// ==== hw/div_stage_chain.sv ====
// restoring subtract chain, zero latency; partial_rem must be below divisor unless divisor is zero
`timescale 1ns/10ps
`default_nettype none

`include "divider_defines.svh"

module div_stage_chain (
    input  wire divider_pkg::div_word_t   partial_rem,
    input  wire divider_pkg::div_digits_t dividend_bits,
    input  wire divider_pkg::div_word_t   divisor,
    output divider_pkg::div_word_t        next_rem,
    output divider_pkg::div_digits_t      digits
);
    import divider_pkg::*;

    // running remainder between stages
    // entry 0 is the registered remainder
    div_word_t rem_chain [0:`DIV_DIGITS_PER_STEP];

    assign rem_chain[0] = partial_rem;

    genvar i;
    for (i = 0; i < `DIV_DIGITS_PER_STEP; i = i + 1) begin : g_stage
        // one extra bit holds the shifted remainder
        logic [`DIV_WIDTH:0] shifted;
        logic [`DIV_WIDTH:0] diff;
        logic                borrow;

        // shift in next dividend bit, msb first
        assign shifted = {rem_chain[i], dividend_bits[`DIV_DIGITS_PER_STEP-1-i]};

        // shifted < 2*divisor, so the top bit is the sign
        assign diff   = shifted - {1'b0, divisor};
        assign borrow = diff[`DIV_WIDTH];

        // quotient bit set when the divisor fits
        assign digits[`DIV_DIGITS_PER_STEP-1-i] = ~borrow;

        // restore on borrow
        // zero divisor never borrows, remainder collects the dividend
        assign rem_chain[i+1] = borrow ? shifted[`DIV_WIDTH-1:0] : diff[`DIV_WIDTH-1:0];
    end

    assign next_rem = rem_chain[`DIV_DIGITS_PER_STEP];

endmodule

`default_nettype wire

// ==== hw/div_datapath.sv ====
// divider registers; operands sampled only on load, results hold until the next finish
`timescale 1ns/10ps
`default_nettype none

`include "divider_defines.svh"

module div_datapath (
    input  wire                           ctl_clk,
    input  wire                           reset,
    input  wire                           load,
    input  wire                           calc_en,
    input  wire                           finish,
    input  wire divider_pkg::div_word_t   dividend,
    input  wire divider_pkg::div_word_t   divisor,
    input  wire divider_pkg::div_digits_t digits,
    input  wire divider_pkg::div_word_t   next_rem,
    output divider_pkg::div_word_t        partial_rem,
    output divider_pkg::div_digits_t      dividend_bits,
    output divider_pkg::div_word_t        divisor_held,
    output divider_pkg::div_word_t        quotient,
    output divider_pkg::div_word_t        remainder,
    output logic                          done
);
    import divider_pkg::*;

    // dividend bits leave at the top, quotient bits enter at the bottom
    // holds the whole quotient after DIV_STEPS shifts
    div_word_t dvd_shift;

    // unconsumed dividend bits for this step
    assign dividend_bits = dvd_shift[`DIV_WIDTH-1 -: `DIV_DIGITS_PER_STEP];

    // working registers
    always_ff @(posedge ctl_clk) begin
        if (load) begin
            divisor_held <= divisor;
            partial_rem  <= '0;
            dvd_shift    <= dividend;
        end else if (calc_en) begin
            partial_rem <= next_rem;
            // one step of dividend out, one step of digits in
            dvd_shift <= {dvd_shift[`DIV_WIDTH-`DIV_DIGITS_PER_STEP-1:0], digits};
        end
    end

    // result registers
    // load may coincide with finish, old values are read here
    always_ff @(posedge ctl_clk) begin
        if (!reset) begin
            quotient  <= '0;
            remainder <= '0;
            done      <= 1'b0;
        end else if (finish) begin
            quotient  <= dvd_shift;
            remainder <= partial_rem;
            done      <= 1'b1;
        end else begin
            // single-cycle pulse
            done <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== hw/divider_top.sv ====
// unsigned restoring divider, DIV_STEPS+1 clocks per result; divide by zero gives all ones and dividend
`timescale 1ns/10ps
`default_nettype none

`include "divider_defines.svh"

module divider_top (
    input  wire                         ctl_clk,
    input  wire                         reset,
    input  wire                         start,
    input  wire divider_pkg::div_word_t dividend,
    input  wire divider_pkg::div_word_t divisor,
    output logic                        ready,
    output logic                        done,
    output divider_pkg::div_word_t      quotient,
    output divider_pkg::div_word_t      remainder
);

    // fsm controls
    logic load;
    logic calc_en;
    logic finish;
    logic last_step;

    // datapath to chain
    divider_pkg::div_word_t   partial_rem;
    divider_pkg::div_digits_t dividend_bits;
    divider_pkg::div_word_t   divisor_held;

    // chain back to datapath
    divider_pkg::div_word_t   next_rem;
    divider_pkg::div_digits_t digits;

    div_control_fsm u_fsm (
        .ctl_clk   (ctl_clk),
        .reset     (reset),
        .start     (start),
        .last_step (last_step),
        .ready     (ready),
        .load      (load),
        .calc_en   (calc_en),
        .finish    (finish)
    );

    div_step_counter u_counter (
        .ctl_clk   (ctl_clk),
        .reset     (reset),
        .calc_en   (calc_en),
        .last_step (last_step)
    );

    div_datapath u_datapath (
        .ctl_clk       (ctl_clk),
        .reset         (reset),
        .load          (load),
        .calc_en       (calc_en),
        .finish        (finish),
        .dividend      (dividend),
        .divisor       (divisor),
        .digits        (digits),
        .next_rem      (next_rem),
        .partial_rem   (partial_rem),
        .dividend_bits (dividend_bits),
        .divisor_held  (divisor_held),
        .quotient      (quotient),
        .remainder     (remainder),
        .done          (done)
    );

    // DIV_DIGITS_PER_STEP quotient bits per clock
    div_stage_chain u_chain (
        .partial_rem   (partial_rem),
        .dividend_bits (dividend_bits),
        .divisor       (divisor_held),
        .next_rem      (next_rem),
        .digits        (digits)
    );

endmodule

`default_nettype wire

// ==== dv/divider_tb.sv ====
// divider testbench; needs hw on the include path, expects each result DIV_STEPS+1 clocks after accept
`timescale 1ns/10ps
`default_nettype none

`include "divider_defines.svh"

module divider_tb;
    import divider_pkg::*;

    // table size and random pair count
    localparam int NUM_ROWS     = 20;
    localparam int NUM_RANDOM   = 40;
    localparam int RESET_CYCLES = 3;

    // clocks from accepting edge to done
    localparam int LATENCY = `DIV_STEPS + 1;

    // bound on any single handshake wait
    localparam int WAIT_LIMIT = 3 * LATENCY;

    // whole run, at most 12 clocks per division
    localparam int WATCHDOG_CYCLES = (NUM_ROWS + NUM_RANDOM) * 12 + RESET_CYCLES;

    logic      ctl_clk;
    logic      reset;
    logic      start;
    div_word_t dividend;
    div_word_t divisor;
    logic      ready;
    logic      done;
    div_word_t quotient;
    div_word_t remainder;

    // stimulus, expected results and idle clocks before start
    div_word_t tbl_dividend  [NUM_ROWS];
    div_word_t tbl_divisor   [NUM_ROWS];
    div_word_t tbl_quotient  [NUM_ROWS];
    div_word_t tbl_remainder [NUM_ROWS];
    int        tbl_gap       [NUM_ROWS];

    // last good results, must hold until the next done
    div_word_t held_quotient;
    div_word_t held_remainder;

    int unsigned cycle_count = 0;
    div_word_t   rng_state;
    int          check_count;
    int          mismatch_count;
    int          other_errors;

    divider_top uut (
        .ctl_clk   (ctl_clk),
        .reset     (reset),
        .start     (start),
        .dividend  (dividend),
        .divisor   (divisor),
        .ready     (ready),
        .done      (done),
        .quotient  (quotient),
        .remainder (remainder)
    );

    // 4 ns clock
    initial begin
        ctl_clk = 1'b0;
        forever begin
            #2 ctl_clk = ~ctl_clk;
        end
    end

    // rising edge count, only read on falling edges
    always @(posedge ctl_clk) begin
        cycle_count <= cycle_count + 1;
    end

    // lcg, numerical recipes constants
    function automatic div_word_t next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // reference results, zero divisor gives all ones
    function automatic div_word_t model_quotient(input div_word_t a, input div_word_t b);
        if (b == '0) begin
            return '1;
        end
        return a / b;
    endfunction

    // zero divisor leaves the dividend
    function automatic div_word_t model_remainder(input div_word_t a, input div_word_t b);
        if (b == '0) begin
            return a;
        end
        return a % b;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, actual, expected);
            mismatch_count++;
        end
    endtask

    task automatic add_row(input int idx, input div_word_t dvd, input div_word_t dsr,
                           input div_word_t q, input div_word_t r, input int gap);
        tbl_dividend[idx]  = dvd;
        tbl_divisor[idx]   = dsr;
        tbl_quotient[idx]  = q;
        tbl_remainder[idx] = r;
        tbl_gap[idx]       = gap;
    endtask

    // dividend, divisor, quotient, remainder, idle clocks
    task automatic fill_table();
        add_row(0,  32'h00000000, 32'h00000001, 32'h00000000, 32'h00000000, 0);
        add_row(1,  32'h00000001, 32'h00000001, 32'h00000001, 32'h00000000, 0);
        add_row(2,  32'h00000000, 32'h00000000, 32'hffffffff, 32'h00000000, 1);
        add_row(3,  32'h00003039, 32'h00000000, 32'hffffffff, 32'h00003039, 0);
        add_row(4,  32'hffffffff, 32'h00000001, 32'hffffffff, 32'h00000000, 2);
        add_row(5,  32'hffffffff, 32'hffffffff, 32'h00000001, 32'h00000000, 0);
        add_row(6,  32'hffffffff, 32'h00000000, 32'hffffffff, 32'hffffffff, 0);
        add_row(7,  32'h00000005, 32'h00000007, 32'h00000000, 32'h00000005, 1);
        add_row(8,  32'h00000001, 32'hffffffff, 32'h00000000, 32'h00000001, 0);
        add_row(9,  32'h80000000, 32'hffffffff, 32'h00000000, 32'h80000000, 0);
        add_row(10, 32'h80000000, 32'h00000002, 32'h40000000, 32'h00000000, 2);
        add_row(11, 32'h80000000, 32'h00000010, 32'h08000000, 32'h00000000, 0);
        add_row(12, 32'h12345678, 32'h00000100, 32'h00123456, 32'h00000078, 0);
        add_row(13, 32'hffffffff, 32'h00010000, 32'h0000ffff, 32'h0000ffff, 1);
        add_row(14, 32'h00000064, 32'h00000007, 32'h0000000e, 32'h00000002, 0);
        add_row(15, 32'hffffffff, 32'h00000003, 32'h55555555, 32'h00000000, 0);
        add_row(16, 32'hffffffff, 32'h80000000, 32'h00000001, 32'h7fffffff, 2);
        add_row(17, 32'hdeadbeef, 32'h00000010, 32'h0deadbee, 32'h0000000f, 0);
        add_row(18, 32'h00000000, 32'hffffffff, 32'h00000000, 32'h00000000, 0);
        add_row(19, 32'h00000007, 32'h00000007, 32'h00000001, 32'h00000000, 1);
    endtask

    // one full handshake; returns on the falling edge of the done cycle
    task automatic run_division(input div_word_t dvd, input div_word_t dsr,
                                input div_word_t exp_q, input div_word_t exp_r, input int gap);
        int unsigned accept_cycle;
        int          waited;

        // idle clocks, done must already be gone
        repeat (gap) begin
            @(negedge ctl_clk);
            check_value("done while idle", 32'(done), 32'd0);
        end

        waited = 0;
        while (ready !== 1'b1 && waited < WAIT_LIMIT) begin
            @(negedge ctl_clk);
            waited++;
        end

        if (ready !== 1'b1) begin
            $display("ready never came back before starting %h / %h", dvd, dsr);
            other_errors++;
        end else begin
            dividend     = dvd;
            divisor      = dsr;
            start        = 1'b1;
            accept_cycle = cycle_count + 1;
            @(negedge ctl_clk);
            start = 1'b0;

            // busy phase, one falling edge per loop pass
            waited = 0;
            while (done !== 1'b1 && waited < WAIT_LIMIT) begin
                check_value("quotient held", quotient, held_quotient);
                check_value("remainder held", remainder, held_remainder);
                if (waited < `DIV_STEPS) begin
                    check_value("ready while busy", 32'(ready), 32'd0);
                end else begin
                    check_value("ready in done state", 32'(ready), 32'd1);
                end
                // stray request with other operands, must be ignored
                if (waited == 2) begin
                    start    = 1'b1;
                    dividend = ~dvd;
                    divisor  = dsr ^ 32'h5a5a0f0f;
                end else if (waited == 3) begin
                    start = 1'b0;
                end
                @(negedge ctl_clk);
                waited++;
            end

            if (done !== 1'b1) begin
                $display("done never rose after starting %h / %h", dvd, dsr);
                other_errors++;
            end else begin
                check_value("done latency", 32'(cycle_count - accept_cycle), 32'(LATENCY));
                check_value("ready with done", 32'(ready), 32'd1);
                check_value("quotient", quotient, exp_q);
                check_value("remainder", remainder, exp_r);
                held_quotient  = exp_q;
                held_remainder = exp_r;
            end
        end
    endtask

    initial begin : main
        div_word_t rand_dividend;
        div_word_t rand_divisor;
        div_word_t shift_src;
        int        rand_gap;

        $timeformat(-9, 2, " ns", 0);
        reset          = 1'b0;
        start          = 1'b0;
        dividend       = '0;
        divisor        = '0;
        rng_state      = 32'h9227010d;
        check_count    = 0;
        mismatch_count = 0;
        other_errors   = 0;
        held_quotient  = '0;
        held_remainder = '0;
        fill_table();

        // reset over RESET_CYCLES rising edges
        repeat (RESET_CYCLES) @(negedge ctl_clk);
        check_value("ready in reset", 32'(ready), 32'd0);
        check_value("done in reset", 32'(done), 32'd0);
        check_value("quotient in reset", quotient, 32'd0);
        check_value("remainder in reset", remainder, 32'd0);
        reset = 1'b1;

        // first edge out of reset
        @(negedge ctl_clk);
        check_value("ready after reset", 32'(ready), 32'd1);
        check_value("done after reset", 32'(done), 32'd0);
        check_value("quotient after reset", quotient, 32'd0);
        check_value("remainder after reset", remainder, 32'd0);

        // directed table, gap 0 starts in the done cycle
        for (int row = 0; row < NUM_ROWS; row++) begin
            run_division(tbl_dividend[row], tbl_divisor[row],
                         tbl_quotient[row], tbl_remainder[row], tbl_gap[row]);
        end

        // random pairs, divisor shifted down for larger quotients
        for (int n = 0; n < NUM_RANDOM; n++) begin
            shift_src     = next_random();
            rand_dividend = next_random();
            rand_divisor  = next_random() >> shift_src[4:0];
            rand_gap      = shift_src[5] ? 1 : 0;
            run_division(rand_dividend, rand_divisor,
                         model_quotient(rand_dividend, rand_divisor),
                         model_remainder(rand_dividend, rand_divisor), rand_gap);
        end

        // last done is a single pulse, results stay
        @(negedge ctl_clk);
        check_value("done after last result", 32'(done), 32'd0);
        check_value("quotient held at end", quotient, held_quotient);
        check_value("remainder held at end", remainder, held_remainder);

        $display("divider_tb: %0d checks, %0d mismatches, %0d other errors",
                 check_count, mismatch_count, other_errors);
        if (mismatch_count == 0 && other_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge ctl_clk);
        $display("timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+hw
hw/divider_pkg.sv
hw/div_control_fsm.sv
hw/div_step_counter.sv
hw/div_stage_chain.sv
hw/div_datapath.sv
hw/divider_top.sv
dv/divider_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/10ps --top-module divider_tb \
    -f all.f -o divider_sim &&
sim_out="$(./obj_dir/divider_sim 2>&1)" &&
printf '%s\n' "$sim_out" &&
printf '%s\n' "$sim_out" | grep -qxF '** PASS **' &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }
